// ==== profiler_settings.svh ====
// Sentinel profiler settings
// Array size, widths and marker encodings

`ifndef PROFILER_SETTINGS_SVH
`define PROFILER_SETTINGS_SVH

// Tiles in the 2x2 array
`define N_TILES 4

// Timestamp and interval width
`define STAMP_W 32

// Per-tile orphan counter width
`define ORPHAN_W 8

// Sentinel instruction words, both are addi x0 encodings
`define SENTINEL_START 32'h5AA0_0013
`define SENTINEL_END   32'h5FF0_0013

// Cycles spent by the marker pair itself
`define MARKER_OVERHEAD 1

`endif

// ==== tile_pkg.sv ====
// Tile-side types

`include "profiler_settings.svh"

package tile_pkg;

  // Retired instruction word
  typedef logic [31:0] instr_t;

  // One bit per tile
  typedef logic [`N_TILES-1:0] tile_mask_t;

  // Tile number within the array
  typedef logic [$clog2(`N_TILES)-1:0] tile_idx_t;

endpackage

// ==== profiling_pkg.sv ====
// Measurement result types

`include "profiler_settings.svh"

package profiling_pkg;

  // Cycle timestamp, also used for latencies and sync intervals
  typedef logic [`STAMP_W-1:0] stamp_t;

  // Saturating count of unmatched end markers
  typedef logic [`ORPHAN_W-1:0] orphan_cnt_t;

endpackage

// ==== tile_sentinel_tracker.sv ====
// Per-tile sentinel tracker
// Start/end pairing, latency and orphan count

`include "profiler_settings.svh"

module tile_sentinel_tracker
  import tile_pkg::*;
  import profiling_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  // Free-running cycle stamp
  input  stamp_t      i_stamp,
  // Retired instruction of this tile
  input  logic        i_instr_valid,
  input  instr_t      i_instr,
  // Pair latency
  output logic        o_lat_valid,
  output stamp_t      o_lat,
  output orphan_cnt_t o_orphan_cnt,
  // Completed pair towards the window tracker
  output logic        o_pair_done,
  output stamp_t      o_pair_start,
  output stamp_t      o_pair_end
);

  logic        is_start;
  logic        is_end;
  logic        pair_hit;
  logic        orphan_hit;
  logic        orphan_sat;

  logic        pending_q;
  stamp_t      start_q;
  stamp_t      lat_d;

  logic        lat_valid_q;
  stamp_t      lat_q;
  stamp_t      pair_start_q;
  stamp_t      pair_end_q;
  orphan_cnt_t orphan_cnt_q;

  // Marker decode, only retired words count
  assign is_start = i_instr_valid && (i_instr == `SENTINEL_START);
  assign is_end   = i_instr_valid && (i_instr == `SENTINEL_END);

  // An end closes the open pair, otherwise it is an orphan
  assign pair_hit   = is_end && pending_q;
  assign orphan_hit = is_end && !pending_q;
  assign orphan_sat = &orphan_cnt_q;

  // Edges between the markers, less the marker cost
  assign lat_d = i_stamp - start_q - stamp_t'(`MARKER_OVERHEAD);

  // Control state
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending_q    <= 1'b0;
      lat_valid_q  <= 1'b0;
      orphan_cnt_q <= '0;
    end else begin
      if (is_start) begin
        pending_q <= 1'b1;
      end else if (pair_hit) begin
        pending_q <= 1'b0;
      end

      // One-cycle pulse after the closing end marker
      lat_valid_q <= pair_hit;

      // Count sticks at its maximum
      if (orphan_hit && !orphan_sat) begin
        orphan_cnt_q <= orphan_cnt_q + orphan_cnt_t'(1);
      end
    end
  end

  // Captured stamps and results
  always_ff @(posedge clk) begin
    // A repeated start simply moves the open pair forward
    if (is_start) begin
      start_q <= i_stamp;
    end
    if (pair_hit) begin
      lat_q        <= lat_d;
      pair_start_q <= start_q;
      pair_end_q   <= i_stamp;
    end
  end

  assign o_lat_valid  = lat_valid_q;
  assign o_lat        = lat_q;
  assign o_orphan_cnt = orphan_cnt_q;

  assign o_pair_done  = lat_valid_q;
  assign o_pair_start = pair_start_q;
  assign o_pair_end   = pair_end_q;

endmodule

// ==== sync_window_tracker.sv ====
// Global sync window tracker
// Latest end minus latest start over one iteration

`include "profiler_settings.svh"

module sync_window_tracker
  import tile_pkg::*;
  import profiling_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst_n,
  // Completed pairs from the tile trackers
  input  tile_mask_t i_pair_done,
  input  stamp_t     i_pair_start [`N_TILES],
  input  stamp_t     i_pair_end   [`N_TILES],
  // Sync time of a finished iteration
  output logic       o_sync_valid,
  output stamp_t     o_sync_cycles
);

  // Iteration state
  tile_mask_t done_q;
  stamp_t     max_start_q;
  stamp_t     max_end_q;

  // Next-state view including this cycle's reports
  tile_mask_t accept;
  tile_mask_t done_d;
  stamp_t     max_start_d;
  stamp_t     max_end_d;
  logic       iter_full;
  stamp_t     sync_d;

  // Result registers
  logic       sync_valid_q;
  stamp_t     sync_cycles_q;

  // Merge every newly reported pair, several tiles may report together
  always_comb begin
    // Tiles already done this iteration are ignored
    accept      = i_pair_done & ~done_q;
    done_d      = done_q | accept;
    max_start_d = max_start_q;
    max_end_d   = max_end_q;
    for (int t = 0; t < `N_TILES; t++) begin
      if (accept[t]) begin
        if (i_pair_start[t] > max_start_d) begin
          max_start_d = i_pair_start[t];
        end
        if (i_pair_end[t] > max_end_d) begin
          max_end_d = i_pair_end[t];
        end
      end
    end
  end

  // Last outstanding tile has reported
  assign iter_full = &done_d;

  assign sync_d = max_end_d - max_start_d - stamp_t'(`MARKER_OVERHEAD);

  // Iteration bookkeeping
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      done_q       <= '0;
      max_start_q  <= '0;
      max_end_q    <= '0;
      sync_valid_q <= 1'b0;
    end else begin
      if (iter_full) begin
        // Start a fresh iteration
        done_q      <= '0;
        max_start_q <= '0;
        max_end_q   <= '0;
      end else begin
        done_q      <= done_d;
        max_start_q <= max_start_d;
        max_end_q   <= max_end_d;
      end
      sync_valid_q <= iter_full;
    end
  end

  // Sync interval, held until the next iteration completes
  always_ff @(posedge clk) begin
    if (iter_full) begin
      sync_cycles_q <= sync_d;
    end
  end

  assign o_sync_valid  = sync_valid_q;
  assign o_sync_cycles = sync_cycles_q;

endmodule

// ==== sync_profiler.sv ====
// Sentinel sync profiler top

`include "profiler_settings.svh"

module sync_profiler
  import tile_pkg::*;
  import profiling_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  // Retired instructions, one lane per tile
  input  tile_mask_t  i_instr_valid,
  input  instr_t      i_instr      [`N_TILES],
  // Per-tile results
  output tile_mask_t  o_lat_valid,
  output stamp_t      o_lat        [`N_TILES],
  output orphan_cnt_t o_orphan_cnt [`N_TILES],
  // Array-wide result
  output logic        o_sync_valid,
  output stamp_t      o_sync_cycles
);

  stamp_t     stamp_q;

  tile_mask_t pair_done;
  stamp_t     pair_start [`N_TILES];
  stamp_t     pair_end   [`N_TILES];

  // Free-running timestamp shared by all tiles
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_q + stamp_t'(1);
    end
  end

  for (genvar g = 0; g < `N_TILES; g++) begin : gen_tile
    localparam tile_idx_t TILE = tile_idx_t'(g);

    tile_sentinel_tracker i_tile_sentinel_tracker (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_stamp       (stamp_q),
      .i_instr_valid (i_instr_valid[TILE]),
      .i_instr       (i_instr[TILE]),
      .o_lat_valid   (o_lat_valid[TILE]),
      .o_lat         (o_lat[TILE]),
      .o_orphan_cnt  (o_orphan_cnt[TILE]),
      .o_pair_done   (pair_done[TILE]),
      .o_pair_start  (pair_start[TILE]),
      .o_pair_end    (pair_end[TILE])
    );
  end

  // One window over the whole array
  sync_window_tracker i_sync_window_tracker (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_pair_done   (pair_done),
    .i_pair_start  (pair_start),
    .i_pair_end    (pair_end),
    .o_sync_valid  (o_sync_valid),
    .o_sync_cycles (o_sync_cycles)
  );

endmodule

// ==== tb_sync_profiler.sv ====
// Sentinel profiler testbench
// Random markers checked against a cycle model

`include "profiler_settings.svh"

module tb_sync_profiler
  import tile_pkg::*;
  import profiling_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_CYCLES  = 3000;
  localparam int MIN_SYNCS    = 20;
  localparam int SYNC_WAIT    = 5000;
  localparam int DRAIN_WAIT   = 8;
  localparam int ORPHAN_BURST = 260;

  logic        clk = 1'b0;
  logic        rst_n;
  tile_mask_t  instr_valid;
  instr_t      instr      [`N_TILES];
  tile_mask_t  lat_valid;
  stamp_t      lat        [`N_TILES];
  orphan_cnt_t orphan_cnt [`N_TILES];
  logic        sync_valid;
  stamp_t      sync_cycles;

  // Stimulus LFSR seeded with 33
  logic [15:0] lfsr_q = 16'd33;

  // Model state for the edge cyc that samples the current inputs
  int unsigned cyc;
  logic        pend_m   [`N_TILES];
  int unsigned start_m  [`N_TILES];
  orphan_cnt_t orphan_m [`N_TILES];
  tile_mask_t  done_m;
  int unsigned max_start_m;
  int unsigned max_end_m;

  // Expected pulses and the edge after which they show
  int unsigned lat_due  [$];
  int          lat_tile [$];
  stamp_t      lat_val  [$];
  int unsigned sync_due [$];
  stamp_t      sync_val [$];

  int          sync_seen;
  stamp_t      first_sync;
  int          error_count;

  always #5 clk = ~clk;

  sync_profiler i_sync_profiler (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .o_lat_valid   (lat_valid),
    .o_lat         (lat),
    .o_orphan_cnt  (orphan_cnt),
    .o_sync_valid  (sync_valid),
    .o_sync_cycles (sync_cycles)
  );

  task automatic report_mismatch(input string name, input stamp_t exp, input stamp_t act);
    error_count++;
    $display("FAIL %s expected %0d actual %0d", name, exp, act);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Tracker and window rules applied to the inputs of edge cyc
  task automatic model_edge();
    tile_mask_t  done_now;
    int unsigned pair_s [`N_TILES];
    int unsigned pair_e [`N_TILES];
    done_now = '0;
    for (int t = 0; t < `N_TILES; t++) begin
      pair_s[t] = 0;
      pair_e[t] = 0;
      if (instr_valid[t] && instr[t] == `SENTINEL_START) begin
        // A second start restarts the open pair
        pend_m[t]  = 1'b1;
        start_m[t] = cyc;
      end else if (instr_valid[t] && instr[t] == `SENTINEL_END) begin
        if (pend_m[t]) begin
          lat_due.push_back(cyc);
          lat_tile.push_back(t);
          lat_val.push_back(stamp_t'(cyc - start_m[t] - 1));
          pair_s[t]   = start_m[t];
          pair_e[t]   = cyc;
          done_now[t] = 1'b1;
          pend_m[t]   = 1'b0;
        end else if (orphan_m[t] != '1) begin
          orphan_m[t] = orphan_m[t] + orphan_cnt_t'(1);
        end
      end
    end
    // Only the first pair of each tile counts toward the latest start and end
    for (int t = 0; t < `N_TILES; t++) begin
      if (done_now[t] && !done_m[t]) begin
        done_m[t] = 1'b1;
        if (pair_s[t] > max_start_m) begin
          max_start_m = pair_s[t];
        end
        if (pair_e[t] > max_end_m) begin
          max_end_m = pair_e[t];
        end
      end
    end
    if (done_m == '1) begin
      sync_due.push_back(cyc + 1);
      sync_val.push_back(stamp_t'(max_end_m - max_start_m - 1));
      done_m      = '0;
      max_start_m = 0;
      max_end_m   = 0;
    end
  endtask

  task automatic check_reset_state();
    assert (lat_valid == '0)
      else report_mismatch("reset latency valid", '0, stamp_t'(lat_valid));
    assert (sync_valid == 1'b0)
      else report_mismatch("reset sync valid", '0, stamp_t'(sync_valid));
    for (int t = 0; t < `N_TILES; t++) begin
      assert (orphan_cnt[t] == '0)
        else report_mismatch($sformatf("reset orphan tile %0d", t), '0, stamp_t'(orphan_cnt[t]));
    end
  endtask

  // Compare the outputs seen after edge cyc with the model
  task automatic check_outputs();
    tile_mask_t exp_v;
    stamp_t     exp_l [`N_TILES];
    logic       exp_s;
    stamp_t     exp_sv;
    exp_v  = '0;
    exp_s  = 1'b0;
    exp_sv = '0;
    for (int t = 0; t < `N_TILES; t++) begin
      exp_l[t] = '0;
    end
    while (lat_due.size() > 0 && lat_due[0] == cyc) begin
      exp_v[lat_tile[0]] = 1'b1;
      exp_l[lat_tile[0]] = lat_val[0];
      void'(lat_due.pop_front());
      void'(lat_tile.pop_front());
      void'(lat_val.pop_front());
    end
    if (sync_due.size() > 0 && sync_due[0] == cyc) begin
      exp_s  = 1'b1;
      exp_sv = sync_val[0];
      void'(sync_due.pop_front());
      void'(sync_val.pop_front());
    end
    for (int t = 0; t < `N_TILES; t++) begin
      assert (lat_valid[t] == exp_v[t])
        else report_mismatch($sformatf("latency valid tile %0d", t),
                             stamp_t'(exp_v[t]), stamp_t'(lat_valid[t]));
      if (exp_v[t]) begin
        assert (lat[t] == exp_l[t])
          else report_mismatch($sformatf("latency tile %0d", t), exp_l[t], lat[t]);
      end
      assert (orphan_cnt[t] == orphan_m[t])
        else report_mismatch($sformatf("orphan count tile %0d", t),
                             stamp_t'(orphan_m[t]), stamp_t'(orphan_cnt[t]));
    end
    assert (sync_valid == exp_s)
      else report_mismatch("sync valid", stamp_t'(exp_s), stamp_t'(sync_valid));
    if (exp_s) begin
      assert (sync_cycles == exp_sv)
        else report_mismatch("sync cycles", exp_sv, sync_cycles);
      sync_seen++;
      if (sync_seen == 1) begin
        first_sync = sync_cycles;
      end
    end
  endtask

  // Inputs are already driven at this falling edge
  task automatic apply_cycle();
    model_edge();
    @(negedge clk);
    check_outputs();
    cyc++;
  endtask

  task automatic step_markers(input tile_mask_t starts, input tile_mask_t ends);
    for (int t = 0; t < `N_TILES; t++) begin
      instr_valid[t] = starts[t] | ends[t];
      if (starts[t]) begin
        instr[t] = `SENTINEL_START;
      end else if (ends[t]) begin
        instr[t] = `SENTINEL_END;
      end else begin
        instr[t] = '0;
      end
    end
    apply_cycle();
  endtask

  task automatic step_random();
    logic [31:0] b;
    for (int t = 0; t < `N_TILES; t++) begin
      draw_bits(1, b);
      instr_valid[t] = b[0];
      draw_bits(2, b);
      case (b[1:0])
        2'd0: instr[t] = `SENTINEL_START;
        2'd1: instr[t] = `SENTINEL_END;
        default: begin
          draw_bits(32, b);
          // Keep filler words off the marker encodings
          if (b == `SENTINEL_START || b == `SENTINEL_END) begin
            b = ~b;
          end
          instr[t] = b;
        end
      endcase
    end
    apply_cycle();
  endtask

  task automatic wait_for_sync(input int target, input int limit, input logic random_fill);
    int waited;
    waited = 0;
    while (sync_seen < target) begin
      if (waited >= limit) begin
        report_error($sformatf("Timed out after %0d cycles waiting for sync result %0d",
                               limit, target));
      end else begin
        if (random_fill) begin
          step_random();
        end else begin
          step_markers('0, '0);
        end
        waited++;
      end
    end
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (lat_due.size() != 0 || sync_due.size() != 0) begin
      if (waited >= DRAIN_WAIT) begin
        report_error("Expected results were still pending after the stimulus stopped");
      end else begin
        step_markers('0, '0);
        waited++;
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    instr_valid = '0;
    for (int t = 0; t < `N_TILES; t++) begin
      instr[t]    = '0;
      pend_m[t]   = 1'b0;
      start_m[t]  = 0;
      orphan_m[t] = '0;
    end
    done_m      = '0;
    max_start_m = 0;
    max_end_m   = 0;
    cyc         = 0;
    sync_seen   = 0;
    first_sync  = '0;
    error_count = 0;

    // Markers seen while in reset must leave no pulse and no count
    for (int i = 0; i < 16; i++) begin
      instr_valid = '1;
      for (int t = 0; t < `N_TILES; t++) begin
        instr[t] = (i % 2 == 0) ? `SENTINEL_START : `SENTINEL_END;
      end
      @(negedge clk);
      check_reset_state();
    end
    rst_n = 1'b1;

    // Tile 0 closes two pairs before tiles 1 to 3 finish
    step_markers(4'b1110, 4'b0000);
    step_markers(4'b0000, 4'b0000);
    step_markers(4'b0001, 4'b0000);
    step_markers(4'b0000, 4'b0000);
    step_markers(4'b0000, 4'b0001);
    step_markers(4'b0000, 4'b0000);
    step_markers(4'b0001, 4'b0000);
    step_markers(4'b0000, 4'b0000);
    step_markers(4'b0000, 4'b0001);
    step_markers(4'b0000, 4'b0000);
    step_markers(4'b0000, 4'b1110);
    wait_for_sync(1, 10, 1'b0);
    // Latest end is 10 and the latest first-pair start is 2
    assert (first_sync == stamp_t'(7))
      else report_mismatch("repeat pair sync", stamp_t'(7), first_sync);

    // Unmatched ends push tile 3 into saturation
    for (int i = 0; i < ORPHAN_BURST; i++) begin
      step_markers(4'b0000, 4'b1000);
    end
    assert (orphan_cnt[3] == {`ORPHAN_W{1'b1}})
      else report_mismatch("orphan saturation", stamp_t'({`ORPHAN_W{1'b1}}),
                           stamp_t'(orphan_cnt[3]));

    for (int i = 0; i < RAND_CYCLES; i++) begin
      step_random();
    end
    wait_for_sync(MIN_SYNCS, SYNC_WAIT, 1'b1);
    drain_results();

    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
tile_pkg.sv
profiling_pkg.sv
tile_sentinel_tracker.sv
sync_window_tracker.sv
sync_profiler.sv
tb_sync_profiler.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the sync profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_sync_profiler
OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

echo "Building $TOP"
verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR" -o "$TOP" \
  -f vlog.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

echo "Running $TOP"
"./$OBJ_DIR/$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation passed"
exit 0
